// ==== dcache_top.f ====
verilog/dcache_pkg.sv
verilog/dcache_ctrl.sv
verilog/tag_array.sv
verilog/data_array.sv
verilog/plru_table.sv
verilog/refill_buffer.sv
verilog/dcache_top.sv
tb/tb_clkgen.sv
tb/dcache_monitor.sv
tb/dcache_chk.sv
tb/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module dcache_tb \
	-f dcache_top.f --Mdir obj_dir -o dcache_sim

out=$(./obj_dir/dcache_sim)
echo "$out"

if echo "$out" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1

// ==== tb/dcache_chk.sv ====
`timescale 1ns/100ps

module dcache_chk (
	input logic                       i_clk,
	input logic                       i_rst,
	input logic                       i_stall,
	input logic                       i_mem_read_we,
	input logic                       i_mem_write_we,
	input dcache_pkg::mem_read_resp_t i_resp
);

	// high from a read request until its last word
	logic read_busy;

	// number of failed assertions
	int fail_count = 0;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			read_busy <= 1'b0;
		end else if (i_mem_read_we) begin
			read_busy <= 1'b1;
		end else if (i_resp.valid && i_resp.last) begin
			read_busy <= 1'b0;
		end
	end

	assert property (@(posedge i_clk) disable iff (i_rst) !(i_mem_read_we && i_mem_write_we))
		else begin
			$error("read and write strobes high in the same cycle");
			fail_count++;
		end

	assert property (@(posedge i_clk) disable iff (i_rst) i_mem_write_we |-> i_stall)
		else begin
			$error("write-back issued while the cache is not stalled");
			fail_count++;
		end

	assert property (@(posedge i_clk) disable iff (i_rst) i_mem_read_we |-> !read_busy)
		else begin
			$error("second read request before the last response word");
			fail_count++;
		end

endmodule

bind dcache_top dcache_chk dcache_chk_inst (
	.i_clk(i_clk),
	.i_rst(i_rst),
	.i_stall(o_stall),
	.i_mem_read_we(o_mem_read_we),
	.i_mem_write_we(o_mem_write_we),
	.i_resp(i_resp)
);

// ==== tb/dcache_monitor.sv ====
`timescale 1ns/100ps

module dcache_monitor #(
	parameter int WORD_PER_LINE = 8,
	parameter int SETS = 8
) (
	input  logic                                  i_clk,
	input  logic                                  i_rst,
	input  logic                                  i_valid,
	input  dcache_pkg::word_t                     i_addr,
	input  dcache_pkg::byte_en_t                  i_wen,
	input  dcache_pkg::word_t                     i_wdata,
	input  logic                                  i_stall,
	input  logic                                  i_rdata_valid,
	input  dcache_pkg::word_t                     i_rdata,
	input  logic                                  i_mem_read_we,
	input  dcache_pkg::mem_read_req_t             i_memread_req,
	input  logic                                  i_mem_write_we,
	input  dcache_pkg::mem_write_req_t            i_memwrite_req,
	input  dcache_pkg::word_t [WORD_PER_LINE-1:0] i_write_data,
	input  logic [1:0]                            i_wb_mode,
	input  dcache_pkg::word_t                     i_wb_addr,
	input  int                                    i_assert_fails,
	input  logic                                  i_done,
	output int                                    o_errors,
	output logic                                  o_reported
);

	localparam dcache_pkg::word_t LINE_MASK = ~dcache_pkg::word_t'(WORD_PER_LINE * 4 - 1);

	dcache_pkg::word_t shadow [dcache_pkg::word_t];
	// lines fetched and not yet written back
	bit resident [dcache_pkg::word_t];
	dcache_pkg::word_t exp_q [$];
	dcache_pkg::word_t key;
	dcache_pkg::word_t merged;
	dcache_pkg::word_t expected;
	dcache_pkg::word_t cur_addr;
	dcache_pkg::word_t cur_wb_addr;
	dcache_pkg::word_t wb_seen_addr;
	logic [1:0] cur_mode;
	logic req_pending;
	logic req_hit;
	logic req_load;
	int mismatches = 0;
	int others = 0;
	int reset_cycles;
	int wb_count;

	initial begin
		o_errors = 0;
		o_reported = 1'b0;
	end

	// unwritten words read as their address xor the fill pattern
	function automatic dcache_pkg::word_t shadow_word(input dcache_pkg::word_t a);
		dcache_pkg::word_t k;
		k = {a[31:2], 2'b00};
		return shadow.exists(k) ? shadow[k] : (k ^ 32'h5c7e912d);
	endfunction

	task automatic report_mismatch(input string name, input dcache_pkg::word_t exp_v,
		input dcache_pkg::word_t act_v);
		$display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp_v, act_v);
		mismatches++;
	endtask

	task automatic report_error(input string msg);
		$display("ERROR time=%0t %s", $time, msg);
		others++;
	endtask

	// mode 1 wants no write-back, mode 2 exactly one at the given line
	task automatic close_request();
		if (cur_mode == 2'd1 && wb_count != 0) begin
			report_error("write-back issued where none was expected");
		end else if (cur_mode == 2'd2) begin
			if (wb_count != 1) begin
				report_mismatch("write-back count", 32'd1, dcache_pkg::word_t'(wb_count));
			end else if (wb_seen_addr !== cur_wb_addr) begin
				report_mismatch("o_memwrite_req.addr", cur_wb_addr, wb_seen_addr);
			end
		end
	endtask

	always @(negedge i_clk) begin
		if (i_rst !== 1'b0) begin
			reset_cycles = 0;
			req_pending = 1'b0;
			cur_mode = 2'd0;
			wb_count = 0;
		end else begin
			if (reset_cycles < SETS) begin
				if (!i_stall || i_rdata_valid || i_mem_read_we || i_mem_write_we) begin
					report_error("cache active during the reset sweep");
				end
				reset_cycles++;
			end
			// a resident line must hit, any other line must start a line read
			if (req_pending) begin
				if (req_hit && i_mem_read_we) begin
					report_error("line read issued for a line already in the cache");
				end else if (req_hit && req_load && !i_rdata_valid) begin
					report_error("load hit gave no data one cycle after accept");
				end else if (!req_hit && !i_mem_read_we) begin
					report_error("miss issued no line read in the cycle after accept");
				end
			end
			req_pending = 1'b0;
			if (i_rdata_valid) begin
				if (exp_q.size() == 0) begin
					report_error("load data with no load outstanding");
				end else begin
					expected = exp_q.pop_front();
					if (i_rdata !== expected) begin
						report_mismatch("o_rdata", expected, i_rdata);
					end
				end
			end
			if (i_mem_read_we) begin
				if (i_memread_req.addr !== (cur_addr & LINE_MASK)) begin
					report_mismatch("o_memread_req.addr", cur_addr & LINE_MASK,
						i_memread_req.addr);
				end
				if (int'(i_memread_req.len) != WORD_PER_LINE - 1) begin
					report_mismatch("o_memread_req.len", WORD_PER_LINE - 1,
						dcache_pkg::word_t'(i_memread_req.len));
				end
				resident[cur_addr & LINE_MASK] = 1'b1;
			end
			if (i_mem_write_we) begin
				wb_count++;
				wb_seen_addr = i_memwrite_req.addr;
				if (int'(i_memwrite_req.len) != WORD_PER_LINE - 1) begin
					report_mismatch("o_memwrite_req.len", WORD_PER_LINE - 1,
						dcache_pkg::word_t'(i_memwrite_req.len));
				end
				if (resident.exists(i_memwrite_req.addr)) begin
					resident.delete(i_memwrite_req.addr);
				end else begin
					report_error("write-back of a line that is not in the cache");
				end
				for (int i = 0; i < WORD_PER_LINE; i++) begin
					expected = shadow_word(i_memwrite_req.addr + dcache_pkg::word_t'(4 * i));
					if (i_write_data[i] !== expected) begin
						report_mismatch("o_write_data", expected, i_write_data[i]);
					end
				end
			end
			if (i_valid && !i_stall) begin
				close_request();
				cur_addr = i_addr;
				cur_mode = i_wb_mode;
				cur_wb_addr = i_wb_addr;
				wb_count = 0;
				req_pending = 1'b1;
				req_hit = resident.exists(i_addr & LINE_MASK);
				req_load = i_wen == 4'b0000;
				if (i_wen == 4'b0000) begin
					exp_q.push_back(shadow_word(i_addr));
				end else begin
					key = {i_addr[31:2], 2'b00};
					merged = shadow_word(key);
					for (int b = 0; b < 4; b++) begin
						if (i_wen[b]) begin
							merged[b*8 +: 8] = i_wdata[b*8 +: 8];
						end
					end
					shadow[key] = merged;
				end
			end
			if (i_done && !o_reported) begin
				close_request();
				if (exp_q.size() != 0) begin
					report_error("loads left without returned data");
				end
				$display("checks done: %0d mismatches, %0d other errors, %0d assertion failures",
					mismatches, others, i_assert_fails);
				o_errors = mismatches + others + i_assert_fails;
				o_reported = 1'b1;
			end
		end
	end

endmodule

// ==== tb/dcache_tb.sv ====
`timescale 1ns/100ps

module dcache_tb;

	localparam int WORD_PER_LINE = 8;
	localparam int SET_ASSOC = 4;
	localparam int CACHE_SIZE = 1024;
	localparam int SETS = CACHE_SIZE / (WORD_PER_LINE * 4) / SET_ASSOC;
	localparam int N_ENTRIES = 18;

	// write-back expectation per entry
	localparam logic [1:0] WB_ANY = 2'd0;
	localparam logic [1:0] WB_NONE = 2'd1;
	localparam logic [1:0] WB_ONE = 2'd2;

	typedef struct packed {
		dcache_pkg::word_t    addr;
		dcache_pkg::byte_en_t wen;
		dcache_pkg::word_t    wdata;
		logic [1:0]           wb_mode;
		dcache_pkg::word_t    wb_addr;
	} entry_t;

	logic clk, rst;
	logic valid, stall, rdata_valid, memwrite_end, mem_read_we, mem_write_we;
	logic done, reported;
	logic [1:0] wb_mode;
	dcache_pkg::word_t addr, wdata, rdata, wb_addr, base;
	dcache_pkg::byte_en_t wen;
	dcache_pkg::mem_read_resp_t resp;
	dcache_pkg::mem_read_req_t memread_req;
	dcache_pkg::mem_write_req_t memwrite_req;
	dcache_pkg::word_t [WORD_PER_LINE-1:0] write_data;
	dcache_pkg::word_t image [dcache_pkg::word_t];
	entry_t stim [N_ENTRIES];
	int errors, len, gap;
	integer seed = 32'h5c7e912d;

	tb_clkgen tb_clkgen_inst (.o_clk(clk), .o_rst(rst));

	dcache_top #(
		.WORD_PER_LINE(WORD_PER_LINE),
		.SET_ASSOC(SET_ASSOC),
		.CACHE_SIZE(CACHE_SIZE)
	) dcache_top_inst (
		.i_clk(clk), .i_rst(rst), .i_valid(valid), .i_addr(addr), .i_wen(wen),
		.i_wdata(wdata), .o_stall(stall), .o_rdata_valid(rdata_valid), .o_rdata(rdata),
		.i_resp(resp), .i_memwrite_end(memwrite_end), .o_mem_read_we(mem_read_we),
		.o_memread_req(memread_req), .o_mem_write_we(mem_write_we),
		.o_memwrite_req(memwrite_req), .o_write_data(write_data)
	);

	dcache_monitor #(
		.WORD_PER_LINE(WORD_PER_LINE),
		.SETS(SETS)
	) dcache_monitor_inst (
		.i_clk(clk), .i_rst(rst), .i_valid(valid), .i_addr(addr), .i_wen(wen),
		.i_wdata(wdata), .i_stall(stall), .i_rdata_valid(rdata_valid), .i_rdata(rdata),
		.i_mem_read_we(mem_read_we), .i_memread_req(memread_req),
		.i_mem_write_we(mem_write_we), .i_memwrite_req(memwrite_req),
		.i_write_data(write_data), .i_wb_mode(wb_mode), .i_wb_addr(wb_addr),
		.i_assert_fails(dcache_top_inst.dcache_chk_inst.fail_count),
		.i_done(done), .o_errors(errors), .o_reported(reported)
	);

	function automatic entry_t make_entry(input dcache_pkg::word_t a,
		input dcache_pkg::byte_en_t w, input dcache_pkg::word_t d, input logic [1:0] m,
		input dcache_pkg::word_t wa);
		return '{addr: a, wen: w, wdata: d, wb_mode: m, wb_addr: wa};
	endfunction

	function automatic dcache_pkg::word_t image_word(input dcache_pkg::word_t a);
		return image.exists(a) ? image[a] : (a ^ 32'h5c7e912d);
	endfunction

	initial begin
		// set 0: miss, hits, partial store merge
		stim[0] = make_entry(32'h0000_0104, 4'b0000, 32'h0, WB_ANY, 32'h0);
		stim[1] = make_entry(32'h0000_0108, 4'b0000, 32'h0, WB_ANY, 32'h0);
		stim[2] = make_entry(32'h0000_010c, 4'b0000, 32'h0, WB_ANY, 32'h0);
		stim[3] = make_entry(32'h0000_0108, 4'b0011, 32'haabb_ccdd, WB_ANY, 32'h0);
		stim[4] = make_entry(32'h0000_0108, 4'b0000, 32'h0, WB_ANY, 32'h0);
		stim[5] = make_entry(32'h0000_0100, 4'b0000, 32'h0, WB_ANY, 32'h0);
		// set 1: store miss allocates
		stim[6] = make_entry(32'h0000_2224, 4'b1100, 32'h1122_3344, WB_ANY, 32'h0);
		stim[7] = make_entry(32'h0000_2224, 4'b0000, 32'h0, WB_ANY, 32'h0);
		stim[8] = make_entry(32'h0000_2220, 4'b0000, 32'h0, WB_ANY, 32'h0);
		stim[9] = make_entry(32'h0000_223c, 4'b0000, 32'h0, WB_ANY, 32'h0);
		// set 7: five lines, the fifth evicts the first
		stim[10] = make_entry(32'h0000_30e0, 4'b0000, 32'h0, WB_NONE, 32'h0);
		stim[11] = make_entry(32'h0000_30e4, 4'b0101, 32'h0f0f_0f0f, WB_NONE, 32'h0);
		stim[12] = make_entry(32'h0000_31e8, 4'b0000, 32'h0, WB_NONE, 32'h0);
		stim[13] = make_entry(32'h0000_32f0, 4'b0000, 32'h0, WB_NONE, 32'h0);
		stim[14] = make_entry(32'h0000_33fc, 4'b0000, 32'h0, WB_NONE, 32'h0);
		stim[15] = make_entry(32'h0000_34e0, 4'b0000, 32'h0, WB_ONE, 32'h0000_30e0);
		stim[16] = make_entry(32'h0000_30e4, 4'b0000, 32'h0, WB_ANY, 32'h0);
		stim[17] = make_entry(32'h0000_30f8, 4'b0000, 32'h0, WB_ANY, 32'h0);
	end

	// stimulus loop, each entry held until accepted
	initial begin
		valid = 1'b0;
		addr = '0;
		wen = '0;
		wdata = '0;
		wb_mode = WB_ANY;
		wb_addr = '0;
		resp = '0;
		memwrite_end = 1'b0;
		done = 1'b0;
		@(negedge rst);
		for (int i = 0; i < N_ENTRIES; i++) begin
			@(posedge clk);
			#1;
			valid = 1'b1;
			addr = stim[i].addr;
			wen = stim[i].wen;
			wdata = stim[i].wdata;
			wb_mode = stim[i].wb_mode;
			wb_addr = stim[i].wb_addr;
			@(negedge clk);
			while (stall) @(negedge clk);
		end
		@(posedge clk);
		#1 valid = 1'b0;
		@(negedge clk);
		while (stall) @(negedge clk);
		repeat (4) @(negedge clk);
		done = 1'b1;
		@(negedge clk);
		while (!reported) @(negedge clk);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// line read: word 0 first, random gaps, last on the final word
	always begin
		@(negedge clk);
		if (mem_read_we) begin
			base = memread_req.addr;
			len = int'(memread_req.len);
			for (int i = 0; i <= len; i++) begin
				gap = $unsigned($random(seed)) % 3;
				repeat (gap) begin
					@(posedge clk);
					#1 resp = '0;
				end
				@(posedge clk);
				#1;
				resp.valid = 1'b1;
				resp.last = (i == len);
				resp.data = image_word(base + dcache_pkg::word_t'(4 * i));
			end
			@(posedge clk);
			#1 resp = '0;
		end
	end

	// write-back lands in the image, completion a few cycles later
	always begin
		@(negedge clk);
		if (mem_write_we) begin
			for (int i = 0; i < WORD_PER_LINE; i++) begin
				image[memwrite_req.addr + dcache_pkg::word_t'(4 * i)] = write_data[i];
			end
			repeat (3) @(posedge clk);
			#1 memwrite_end = 1'b1;
			@(posedge clk);
			#1 memwrite_end = 1'b0;
		end
	end

	initial begin
		#((N_ENTRIES * 80 + SETS + 10) * 100);
		$display("timeout: the cache did not finish the stimulus table in time");
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen (
	output logic o_clk,
	output logic o_rst
);

	// 100 ns period
	initial o_clk = 1'b0;
	always #50 o_clk = ~o_clk;

	initial begin
		o_rst = 1'b1;
		repeat (2) @(posedge o_clk);
		#1 o_rst = 1'b0;
	end

endmodule

// ==== verilog/data_array.sv ====
`timescale 1ns/100ps

module data_array #(
	parameter int WORD_PER_LINE = 8,
	parameter int SET_ASSOC = 4,
	parameter int CACHE_SIZE = 1024,
	localparam int SETS = CACHE_SIZE / (WORD_PER_LINE * 4) / SET_ASSOC,
	localparam int INDEX_W = $clog2(SETS),
	localparam int WORD_W = $clog2(WORD_PER_LINE)
) (
	input  logic                                                  i_clk,
	input  logic [INDEX_W-1:0]                                    i_raddr,
	input  logic [INDEX_W-1:0]                                    i_waddr,
	input  logic [SET_ASSOC-1:0]                                  i_wen,
	input  logic [WORD_W-1:0]                                     i_word_sel,
	input  dcache_pkg::byte_en_t                                  i_wbyteen,
	input  dcache_pkg::word_t [WORD_PER_LINE-1:0]                 i_line,
	input  dcache_pkg::word_t                                     i_wdata,
	input  logic                                                  i_refill,
	output dcache_pkg::word_t [SET_ASSOC-1:0][WORD_PER_LINE-1:0]  o_rdata
);

	typedef dcache_pkg::word_t [WORD_PER_LINE-1:0] line_t;

	for (genvar w = 0; w < SET_ASSOC; w++) begin : g_way
		line_t mem [SETS];
		line_t rd_q;

		always_ff @(posedge i_clk) begin
			if (i_wen[w] && i_refill) begin
				mem[i_waddr] <= i_line;
			end else if (i_wen[w]) begin
				// byte merge into the selected word
				for (int b = 0; b < 4; b++) begin
					if (i_wbyteen[b]) begin
						mem[i_waddr][i_word_sel][b*8 +: 8] <= i_wdata[b*8 +: 8];
					end
				end
			end
			rd_q <= mem[i_raddr];
		end

		assign o_rdata[w] = rd_q;
	end

endmodule

// ==== verilog/dcache_ctrl.sv ====
`timescale 1ns/100ps

module dcache_ctrl #(
	parameter int WORD_PER_LINE = 8,
	parameter int SET_ASSOC = 4,
	parameter int CACHE_SIZE = 1024,
	localparam int SETS = CACHE_SIZE / (WORD_PER_LINE * 4) / SET_ASSOC,
	localparam int OFFSET_W = $clog2(WORD_PER_LINE * 4),
	localparam int INDEX_W = $clog2(SETS),
	localparam int TAG_W = 32 - INDEX_W - OFFSET_W,
	localparam int WAY_W = $clog2(SET_ASSOC),
	localparam int WORD_W = $clog2(WORD_PER_LINE)
) (
	input  logic                                                  i_clk,
	input  logic                                                  i_rst,
	input  logic                                                  i_valid,
	input  dcache_pkg::word_t                                     i_addr,
	input  dcache_pkg::byte_en_t                                  i_wen,
	input  dcache_pkg::word_t                                     i_wdata,
	input  logic [SET_ASSOC-1:0]                                  i_hit,
	input  logic [WAY_W-1:0]                                      i_hit_way,
	input  logic [SET_ASSOC-1:0][TAG_W:0]                         i_tags,
	input  dcache_pkg::word_t [SET_ASSOC-1:0][WORD_PER_LINE-1:0]  i_rdata,
	input  logic [WAY_W-1:0]                                      i_victim,
	input  logic                                                  i_refill_done,
	input  dcache_pkg::word_t [WORD_PER_LINE-1:0]                 i_line,
	input  logic                                                  i_memwrite_end,
	output logic [INDEX_W-1:0]                                    o_raddr,
	output logic [SET_ASSOC-1:0]                                  o_tag_wen,
	output logic [INDEX_W-1:0]                                    o_tag_waddr,
	output logic [TAG_W-1:0]                                      o_tag_wtag,
	output logic                                                  o_tag_wvalid,
	output logic [TAG_W-1:0]                                      o_addr_tag,
	output logic [SET_ASSOC-1:0]                                  o_data_wen,
	output logic [INDEX_W-1:0]                                    o_data_waddr,
	output logic [WORD_W-1:0]                                     o_word_sel,
	output dcache_pkg::byte_en_t                                  o_wbyteen,
	output dcache_pkg::word_t [WORD_PER_LINE-1:0]                 o_data_line,
	output dcache_pkg::word_t                                     o_data_wdata,
	output logic                                                  o_data_refill,
	output logic [INDEX_W-1:0]                                    o_plru_index,
	output logic                                                  o_plru_hit_upd,
	output logic                                                  o_plru_miss_upd,
	output logic                                                  o_stall,
	output logic                                                  o_rdata_valid,
	output dcache_pkg::word_t                                     o_rdata,
	output logic                                                  o_mem_read_we,
	output dcache_pkg::mem_read_req_t                             o_memread_req,
	output logic                                                  o_mem_write_we,
	output dcache_pkg::mem_write_req_t                            o_memwrite_req,
	output dcache_pkg::word_t [WORD_PER_LINE-1:0]                 o_write_data
);

	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [WAY_W-1:0] way_t;
	typedef logic [WORD_W-1:0] word_sel_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
	} tag_entry_t;

	// one request as it moves through the lookup
	typedef struct packed {
		dcache_pkg::word_t    addr;
		dcache_pkg::byte_en_t wen;
		dcache_pkg::word_t    wdata;
	} req_t;

	function automatic index_t index_of(input dcache_pkg::word_t addr);
		return addr[OFFSET_W +: INDEX_W];
	endfunction

	function automatic tag_t tag_of(input dcache_pkg::word_t addr);
		return addr[31 -: TAG_W];
	endfunction

	dcache_pkg::ctrl_state_t state_q, state_d;
	index_t sweep_q;
	logic stage_valid_q;
	req_t stage_q, save_q;
	way_t save_way_q;
	tag_entry_t save_vic_q;
	logic [SET_ASSOC-1:0] save_onehot;
	logic stage_hit, stage_store, miss, accept;
	word_sel_t stage_word;

	assign stage_store = |stage_q.wen;
	assign stage_word = stage_q.addr[2 +: WORD_W];
	assign stage_hit = stage_valid_q && (|i_hit);
	assign miss = state_q == dcache_pkg::IDLE && stage_valid_q && !(|i_hit);
	// a store holds off the next request so it cannot read stale data
	assign o_stall = state_q != dcache_pkg::IDLE || (stage_valid_q && (stage_store || !(|i_hit)));
	assign accept = i_valid && !o_stall;
	assign save_onehot = {{(SET_ASSOC-1){1'b0}}, 1'b1} << save_way_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			dcache_pkg::INVALIDATING: if (&sweep_q) state_d = dcache_pkg::IDLE;
			dcache_pkg::IDLE: if (miss) state_d = dcache_pkg::RECEIVING;
			dcache_pkg::RECEIVING: begin
				if (i_refill_done) begin
					state_d = save_vic_q.valid ? dcache_pkg::WRITE_WAITING : dcache_pkg::REFILL;
				end
			end
			dcache_pkg::WRITE_WAITING: if (i_memwrite_end) state_d = dcache_pkg::REFILL;
			dcache_pkg::REFILL: state_d = dcache_pkg::REPLAY;
			dcache_pkg::REPLAY: state_d = dcache_pkg::IDLE;
			default: state_d = dcache_pkg::IDLE;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state_q <= dcache_pkg::INVALIDATING;
			sweep_q <= '0;
			stage_valid_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == dcache_pkg::INVALIDATING) begin
				sweep_q <= sweep_q + 1'b1;
			end
			stage_valid_q <= accept || state_q == dcache_pkg::REPLAY;
		end
	end

	// lookup stage and miss context
	always_ff @(posedge i_clk) begin
		if (accept) begin
			stage_q <= '{addr: i_addr, wen: i_wen, wdata: i_wdata};
		end else if (state_q == dcache_pkg::REPLAY) begin
			stage_q <= save_q;
		end
		if (miss) begin
			save_q <= stage_q;
			save_way_q <= i_victim;
			save_vic_q <= i_tags[i_victim];
		end
	end

	// after a miss the arrays keep reading the saved set for write-back and replay
	always_comb begin
		if (state_q == dcache_pkg::IDLE && !o_stall) begin
			o_raddr = index_of(i_addr);
		end else if (state_q == dcache_pkg::IDLE) begin
			o_raddr = index_of(stage_q.addr);
		end else begin
			o_raddr = index_of(save_q.addr);
		end
	end

	always_comb begin
		o_tag_wen = '0;
		o_tag_waddr = index_of(save_q.addr);
		o_tag_wtag = tag_of(save_q.addr);
		o_tag_wvalid = 1'b1;
		if (state_q == dcache_pkg::INVALIDATING) begin
			o_tag_wen = '1;
			o_tag_waddr = sweep_q;
			o_tag_wtag = '0;
			o_tag_wvalid = 1'b0;
		end else if (state_q == dcache_pkg::REFILL) begin
			o_tag_wen = save_onehot;
		end
	end
	assign o_addr_tag = tag_of(stage_q.addr);

	// refill writes the whole line, a store hit one word
	assign o_data_refill = state_q == dcache_pkg::REFILL;
	assign o_data_wen = o_data_refill ? save_onehot : ((stage_hit && stage_store) ? i_hit : '0);
	assign o_data_waddr = o_data_refill ? index_of(save_q.addr) : index_of(stage_q.addr);
	assign o_word_sel = stage_word;
	assign o_wbyteen = stage_q.wen;
	assign o_data_wdata = stage_q.wdata;
	assign o_data_line = i_line;

	assign o_plru_index = index_of(stage_q.addr);
	assign o_plru_hit_upd = stage_hit;
	assign o_plru_miss_upd = miss;

	assign o_rdata_valid = stage_hit && !stage_store;
	assign o_rdata = i_rdata[i_hit_way][stage_word];

	assign o_mem_read_we = miss;
	assign o_memread_req.addr = {stage_q.addr[31:OFFSET_W], {OFFSET_W{1'b0}}};
	assign o_memread_req.len = dcache_pkg::burst_len_t'(WORD_PER_LINE - 1);

	// victim goes out once the new line has fully arrived
	assign o_mem_write_we = state_q == dcache_pkg::RECEIVING && i_refill_done && save_vic_q.valid;
	assign o_memwrite_req.addr = {save_vic_q.tag, index_of(save_q.addr), {OFFSET_W{1'b0}}};
	assign o_memwrite_req.len = dcache_pkg::burst_len_t'(WORD_PER_LINE - 1);
	assign o_write_data = i_rdata[save_way_q];

endmodule

// ==== verilog/dcache_pkg.sv ====
package dcache_pkg;

	// one data or address word
	typedef logic [31:0] word_t;

	// store byte enables, all zero for a load
	typedef logic [3:0] byte_en_t;

	// burst length minus one
	typedef logic [7:0] burst_len_t;

	// line read request, address is line aligned
	typedef struct packed {
		word_t      addr;
		burst_len_t len;
	} mem_read_req_t;

	// streamed read response, one word per valid cycle
	typedef struct packed {
		logic  valid;
		logic  last;
		word_t data;
	} mem_read_resp_t;

	// line write-back request, data travels beside it
	typedef struct packed {
		word_t      addr;
		burst_len_t len;
	} mem_write_req_t;

	// cache controller states
	typedef enum logic [2:0] {
		INVALIDATING,
		IDLE,
		RECEIVING,
		WRITE_WAITING,
		REFILL,
		REPLAY
	} ctrl_state_t;

endpackage

// ==== verilog/dcache_top.sv ====
`timescale 1ns/100ps

module dcache_top #(
	parameter int WORD_PER_LINE = 8,
	parameter int SET_ASSOC = 4,
	parameter int CACHE_SIZE = 1024
) (
	input  logic                                        i_clk,
	input  logic                                        i_rst,
	input  logic                                        i_valid,
	input  dcache_pkg::word_t                           i_addr,
	input  dcache_pkg::byte_en_t                        i_wen,
	input  dcache_pkg::word_t                           i_wdata,
	output logic                                        o_stall,
	output logic                                        o_rdata_valid,
	output dcache_pkg::word_t                           o_rdata,
	input  dcache_pkg::mem_read_resp_t                  i_resp,
	input  logic                                        i_memwrite_end,
	output logic                                        o_mem_read_we,
	output dcache_pkg::mem_read_req_t                   o_memread_req,
	output logic                                        o_mem_write_we,
	output dcache_pkg::mem_write_req_t                  o_memwrite_req,
	output dcache_pkg::word_t [WORD_PER_LINE-1:0]       o_write_data
);

	localparam int SETS = CACHE_SIZE / (WORD_PER_LINE * 4) / SET_ASSOC;
	localparam int INDEX_W = $clog2(SETS);
	localparam int TAG_W = 32 - INDEX_W - $clog2(WORD_PER_LINE * 4);
	localparam int WAY_W = $clog2(SET_ASSOC);
	localparam int WORD_W = $clog2(WORD_PER_LINE);

	logic [INDEX_W-1:0] raddr;
	logic [INDEX_W-1:0] tag_waddr;
	logic [INDEX_W-1:0] data_waddr;
	logic [INDEX_W-1:0] plru_index;
	logic [SET_ASSOC-1:0] hit;
	logic [SET_ASSOC-1:0] tag_wen;
	logic [SET_ASSOC-1:0] data_wen;
	logic [WAY_W-1:0] hit_way;
	logic [WAY_W-1:0] victim;
	logic [SET_ASSOC-1:0][TAG_W:0] tags;
	logic [TAG_W-1:0] tag_wtag;
	logic [TAG_W-1:0] addr_tag;
	logic tag_wvalid;
	logic data_refill;
	logic plru_hit_upd;
	logic plru_miss_upd;
	logic refill_done;
	logic [WORD_W-1:0] word_sel;
	dcache_pkg::byte_en_t wbyteen;
	dcache_pkg::word_t data_wdata;
	dcache_pkg::word_t [WORD_PER_LINE-1:0] refill_line;
	dcache_pkg::word_t [WORD_PER_LINE-1:0] data_line;
	dcache_pkg::word_t [SET_ASSOC-1:0][WORD_PER_LINE-1:0] rdata_all;

	dcache_ctrl #(
		.WORD_PER_LINE(WORD_PER_LINE),
		.SET_ASSOC(SET_ASSOC),
		.CACHE_SIZE(CACHE_SIZE)
	) dcache_ctrl_inst (
		.i_clk, .i_rst, .i_valid, .i_addr, .i_wen, .i_wdata,
		.i_hit(hit), .i_hit_way(hit_way), .i_tags(tags), .i_rdata(rdata_all),
		.i_victim(victim), .i_refill_done(refill_done), .i_line(refill_line),
		.i_memwrite_end,
		.o_raddr(raddr), .o_tag_wen(tag_wen), .o_tag_waddr(tag_waddr),
		.o_tag_wtag(tag_wtag), .o_tag_wvalid(tag_wvalid), .o_addr_tag(addr_tag),
		.o_data_wen(data_wen), .o_data_waddr(data_waddr), .o_word_sel(word_sel),
		.o_wbyteen(wbyteen), .o_data_line(data_line), .o_data_wdata(data_wdata),
		.o_data_refill(data_refill), .o_plru_index(plru_index),
		.o_plru_hit_upd(plru_hit_upd), .o_plru_miss_upd(plru_miss_upd),
		.o_stall, .o_rdata_valid, .o_rdata,
		.o_mem_read_we, .o_memread_req, .o_mem_write_we, .o_memwrite_req, .o_write_data
	);

	tag_array #(
		.WORD_PER_LINE(WORD_PER_LINE),
		.SET_ASSOC(SET_ASSOC),
		.CACHE_SIZE(CACHE_SIZE)
	) tag_array_inst (
		.i_clk, .i_rst, .i_raddr(raddr), .i_wen(tag_wen), .i_waddr(tag_waddr),
		.i_wtag(tag_wtag), .i_wvalid(tag_wvalid), .i_addr_tag(addr_tag),
		.o_hit(hit), .o_hit_way(hit_way), .o_tags(tags)
	);

	data_array #(
		.WORD_PER_LINE(WORD_PER_LINE),
		.SET_ASSOC(SET_ASSOC),
		.CACHE_SIZE(CACHE_SIZE)
	) data_array_inst (
		.i_clk, .i_raddr(raddr), .i_waddr(data_waddr), .i_wen(data_wen),
		.i_word_sel(word_sel), .i_wbyteen(wbyteen), .i_line(data_line),
		.i_wdata(data_wdata), .i_refill(data_refill), .o_rdata(rdata_all)
	);

	plru_table #(
		.WORD_PER_LINE(WORD_PER_LINE),
		.SET_ASSOC(SET_ASSOC),
		.CACHE_SIZE(CACHE_SIZE)
	) plru_table_inst (
		.i_clk, .i_rst, .i_index(plru_index), .i_hit_upd(plru_hit_upd),
		.i_hit_way(hit_way), .i_miss_upd(plru_miss_upd), .o_victim(victim)
	);

	refill_buffer #(
		.WORD_PER_LINE(WORD_PER_LINE)
	) refill_buffer_inst (
		.i_clk, .i_rst, .i_start(o_mem_read_we), .i_resp,
		.o_line(refill_line), .o_done(refill_done)
	);

endmodule

// ==== verilog/plru_table.sv ====
`timescale 1ns/100ps

module plru_table #(
	parameter int WORD_PER_LINE = 8,
	parameter int SET_ASSOC = 4,
	parameter int CACHE_SIZE = 1024,
	localparam int SETS = CACHE_SIZE / (WORD_PER_LINE * 4) / SET_ASSOC,
	localparam int INDEX_W = $clog2(SETS),
	localparam int WAY_W = $clog2(SET_ASSOC),
	localparam int LRU_W = SET_ASSOC - 1
) (
	input  logic               i_clk,
	input  logic               i_rst,
	input  logic [INDEX_W-1:0] i_index,
	input  logic               i_hit_upd,
	input  logic [WAY_W-1:0]   i_hit_way,
	input  logic               i_miss_upd,
	output logic [WAY_W-1:0]   o_victim
);

	typedef logic [LRU_W-1:0] lru_t;
	typedef logic [WAY_W-1:0] way_t;

	lru_t [SETS-1:0] lru_q;
	lru_t cur, nxt;
	way_t upd_way;

	assign cur = lru_q[i_index];
	// a miss marks the way just named as victim
	assign upd_way = i_hit_upd ? i_hit_way : o_victim;

	if (SET_ASSOC == 2) begin : g_two
		assign o_victim = ~cur;
		assign nxt = upd_way;
	end else begin : g_four
		always_comb begin
			o_victim = cur[1] ? (cur[0] ? 2'd0 : 2'd1) : (cur[2] ? 2'd2 : 2'd3);
			case (upd_way)
				2'd0: nxt = {cur[2], 2'b00};
				2'd1: nxt = {cur[2], 2'b01};
				2'd2: nxt = {2'b01, cur[0]};
				default: nxt = {2'b11, cur[0]};
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			lru_q <= '0;
		end else if (i_hit_upd || i_miss_upd) begin
			lru_q[i_index] <= nxt;
		end
	end

endmodule

// ==== verilog/refill_buffer.sv ====
`timescale 1ns/100ps

module refill_buffer #(
	parameter int WORD_PER_LINE = 8,
	localparam int WORD_W = $clog2(WORD_PER_LINE)
) (
	input  logic                                  i_clk,
	input  logic                                  i_rst,
	input  logic                                  i_start,
	input  dcache_pkg::mem_read_resp_t            i_resp,
	output dcache_pkg::word_t [WORD_PER_LINE-1:0] o_line,
	output logic                                  o_done
);

	typedef logic [WORD_W-1:0] word_sel_t;

	word_sel_t cnt_q;

	// words arrive in order from word 0, gaps allowed
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			cnt_q <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= i_resp.valid && i_resp.last;
			if (i_start) begin
				cnt_q <= '0;
			end else if (i_resp.valid) begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_resp.valid) begin
			o_line[cnt_q] <= i_resp.data;
		end
	end

endmodule

// ==== verilog/tag_array.sv ====
`timescale 1ns/100ps

module tag_array #(
	parameter int WORD_PER_LINE = 8,
	parameter int SET_ASSOC = 4,
	parameter int CACHE_SIZE = 1024,
	localparam int SETS = CACHE_SIZE / (WORD_PER_LINE * 4) / SET_ASSOC,
	localparam int INDEX_W = $clog2(SETS),
	localparam int TAG_W = 32 - INDEX_W - $clog2(WORD_PER_LINE * 4),
	localparam int WAY_W = $clog2(SET_ASSOC)
) (
	input  logic                          i_clk,
	input  logic                          i_rst,
	input  logic [INDEX_W-1:0]            i_raddr,
	input  logic [SET_ASSOC-1:0]          i_wen,
	input  logic [INDEX_W-1:0]            i_waddr,
	input  logic [TAG_W-1:0]              i_wtag,
	input  logic                          i_wvalid,
	input  logic [TAG_W-1:0]              i_addr_tag,
	output logic [SET_ASSOC-1:0]          o_hit,
	output logic [WAY_W-1:0]              o_hit_way,
	output logic [SET_ASSOC-1:0][TAG_W:0] o_tags
);

	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [WAY_W-1:0] way_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
	} tag_entry_t;

	for (genvar w = 0; w < SET_ASSOC; w++) begin : g_way
		tag_entry_t mem [SETS];
		tag_entry_t rd_q;

		// sweep and refill share this port
		always_ff @(posedge i_clk) begin
			if (i_wen[w]) begin
				mem[i_waddr] <= '{valid: i_wvalid, tag: i_wtag};
			end
		end

		always_ff @(posedge i_clk) begin
			if (i_rst) begin
				rd_q <= '0;
			end else begin
				rd_q <= mem[i_raddr];
			end
		end

		assign o_tags[w] = rd_q;
		assign o_hit[w] = rd_q.valid && rd_q.tag == i_addr_tag;
	end

	// at most one way matches
	always_comb begin
		o_hit_way = '0;
		for (int w = 0; w < SET_ASSOC; w++) begin
			if (o_hit[w]) begin
				o_hit_way = way_t'(w);
			end
		end
	end

endmodule
